//--- common/clic_pkg.sv
// shared widths, typedefs, csr operation enum, fixed csr addresses and csr update function
package clic_pkg;

  // instruction memory is byte addressed
  localparam int IMemAddrWidth = 16;

  // csr data word as seen on the core's csr port
  typedef logic [31:0] word_t;

  // 12 bit csr address space
  typedef logic [11:0] csr_addr_t;

  // byte pc of the fetch stage
  typedef logic [IMemAddrWidth-1:0] pc_t;

  // word address, vector csrs hold this
  typedef logic [IMemAddrWidth-3:0] vec_t;

  // immediate of csrrwi / csrrsi / csrrci
  typedef logic [4:0] zimm_t;

  // csr instruction flavours, csr_none means no access
  typedef enum logic [2:0] {
    csr_none,
    csr_rw,
    csr_rs,
    csr_rc,
    csr_rwi,
    csr_rsi,
    csr_rci
  } csr_op_t;

  // fixed machine level csrs
  localparam csr_addr_t MIntThreshAddr = 12'h347;
  localparam csr_addr_t StackDepthAddr = 12'h350;

  // pc value the core presents on mret
  localparam pc_t ReturnPc = '1;

  // next value of a csr for one access, full word wide
  // the caller truncates to the register width
  function automatic word_t csr_apply(csr_op_t op, word_t cur, word_t rs1_data,
                                      zimm_t rs1_zimm);
    word_t operand;
    // immediate forms zero extend the 5 bit field
    operand = (op inside {csr_rwi, csr_rsi, csr_rci}) ? word_t'(rs1_zimm) : rs1_data;
    case (op)
      csr_rw, csr_rwi: csr_apply = operand;
      csr_rs, csr_rsi: csr_apply = cur | operand;
      csr_rc, csr_rci: csr_apply = cur & ~operand;
      default: csr_apply = cur;
    endcase
  endfunction

endpackage

//--- clic/csr_reg.sv
// single csr register with rw/rs/rc access and a hardware write port
`timescale 1ns/1ns

module csr_reg #(
  parameter int Width = 32,
  parameter clic_pkg::csr_addr_t Addr = '0,
  parameter logic [Width-1:0] ResetValue = '0
) (
  input  logic                 clk,
  input  logic                 arst_n,
  // csr port of the core
  input  logic                 csr_enable,
  input  clic_pkg::csr_addr_t  csr_addr,
  input  clic_pkg::zimm_t      rs1_zimm,
  input  clic_pkg::word_t      rs1_data,
  input  clic_pkg::csr_op_t    csr_op,
  // hardware side update
  input  logic                 ext_write_enable,
  input  logic [Width-1:0]     ext_data,
  output logic [Width-1:0]     data
);
  import clic_pkg::*;

  logic             hit;
  word_t            csr_next;
  logic [Width-1:0] data_next;

  // own address decode, csr_none never writes
  assign hit = csr_enable && (csr_op != csr_none) && (csr_addr == Addr);

  // result of the access on the current value, full word
  assign csr_next = csr_apply(csr_op, word_t'(data), rs1_data, rs1_zimm);

  always_comb begin
    data_next = data;
    // hardware wins over software
    if (ext_write_enable) begin
      data_next = ext_data;
    end else if (hit) begin
      // upper operand bits fall away here
      data_next = csr_next[Width-1:0];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data <= ResetValue;
    end else begin
      data <= data_next;
    end
  end

endmodule

//--- clic/clic_vec_table.sv
// vector and entry csrs per interrupt, pend capture and highest priority select
`timescale 1ns/1ns

module clic_vec_table #(
  parameter  int VecSize      = 8,
  parameter  int PrioLevels   = 8,
  parameter  int VecCsrBase   = 'hb00,
  parameter  int EntryCsrBase = 'hb20,
  localparam int PrioWidth    = $clog2(PrioLevels),
  localparam int IdxWidth     = (VecSize > 1) ? $clog2(VecSize) : 1
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 csr_enable,
  input  clic_pkg::csr_addr_t  csr_addr,
  input  clic_pkg::zimm_t      rs1_zimm,
  input  clic_pkg::word_t      rs1_data,
  input  clic_pkg::csr_op_t    csr_op,
  // level interrupt lines
  input  logic [VecSize-1:0]   irq,
  input  logic [PrioWidth-1:0] thresh,
  // pulse from control, clears the winner's pend
  input  logic                 take,
  output logic                 is_int,
  output logic [PrioWidth-1:0] win_prio,
  output clic_pkg::vec_t       win_vec,
  output logic [IdxWidth-1:0]  win_idx,
  output clic_pkg::word_t      rdata_tbl
);
  import clic_pkg::*;

  // entry layout, prio on top, enabled, pended in bit 0
  localparam int EntryWidth = PrioWidth + 2;

  vec_t                  vec_q   [VecSize];
  logic [EntryWidth-1:0] entry_q [VecSize];

  for (genvar k = 0; k < VecSize; k++) begin : gen_vec
    logic                  entry_hit;
    word_t                 entry_csr;
    logic [EntryWidth-1:0] entry_base;
    logic                  pend_clr;
    logic                  entry_we;
    logic [EntryWidth-1:0] entry_wd;

    // vector word address, software only
    csr_reg #(
      .Width(IMemAddrWidth - 2),
      .Addr (csr_addr_t'(VecCsrBase + k))
    ) u_vec (
      .clk             (clk),
      .arst_n          (arst_n),
      .csr_enable      (csr_enable),
      .csr_addr        (csr_addr),
      .rs1_zimm        (rs1_zimm),
      .rs1_data        (rs1_data),
      .csr_op          (csr_op),
      .ext_write_enable(1'b0),
      .ext_data        ('0),
      .data            (vec_q[k])
    );

    // same cycle software access, so a csr write is not lost under an irq
    assign entry_hit  = csr_enable && (csr_op != csr_none)
                        && (csr_addr == csr_addr_t'(EntryCsrBase + k));
    assign entry_csr  = csr_apply(csr_op, word_t'(entry_q[k]), rs1_data, rs1_zimm);
    assign entry_base = entry_hit ? entry_csr[EntryWidth-1:0] : entry_q[k];

    // take clear beats irq set, irq set beats csr clear
    assign pend_clr = take && (win_idx == IdxWidth'(k));
    assign entry_we = irq[k] || pend_clr;
    assign entry_wd = {entry_base[EntryWidth-1:1], irq[k] && !pend_clr};

    csr_reg #(
      .Width(EntryWidth),
      .Addr (csr_addr_t'(EntryCsrBase + k))
    ) u_entry (
      .clk             (clk),
      .arst_n          (arst_n),
      .csr_enable      (csr_enable),
      .csr_addr        (csr_addr),
      .rs1_zimm        (rs1_zimm),
      .rs1_data        (rs1_data),
      .csr_op          (csr_op),
      .ext_write_enable(entry_we),
      .ext_data        (entry_wd),
      .data            (entry_q[k])
    );
  end

  // ripple from index 0, strict compare keeps the lowest index on a tie
  // starting at thresh gives the "above threshold" rule for free
  always_comb begin
    is_int   = 1'b0;
    win_prio = thresh;
    win_vec  = '0;
    win_idx  = '0;
    for (int k = 0; k < VecSize; k++) begin
      if (entry_q[k][0] && entry_q[k][1] && (entry_q[k][EntryWidth-1:2] > win_prio)) begin
        is_int   = 1'b1;
        win_prio = entry_q[k][EntryWidth-1:2];
        win_vec  = vec_q[k];
        win_idx  = IdxWidth'(k);
      end
    end
  end

  // read side, anything not in the table reads zero
  always_comb begin
    rdata_tbl = '0;
    for (int k = 0; k < VecSize; k++) begin
      if (csr_addr == csr_addr_t'(VecCsrBase + k)) begin
        rdata_tbl = word_t'(vec_q[k]);
      end
      if (csr_addr == csr_addr_t'(EntryCsrBase + k)) begin
        rdata_tbl = word_t'(entry_q[k]);
      end
    end
  end

endmodule

//--- clic/epc_stack.sv
// lifo of interrupted pc and threshold pairs with depth counter
`timescale 1ns/1ns

module epc_stack #(
  parameter  int Depth     = 8,
  parameter  int PrioWidth = 3,
  localparam int CntWidth  = $clog2(Depth + 1),
  localparam int PtrWidth  = (Depth > 1) ? $clog2(Depth) : 1
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 push,
  input  logic                 pop,
  input  clic_pkg::pc_t        push_pc,
  input  logic [PrioWidth-1:0] push_prio,
  output clic_pkg::pc_t        top_pc,
  output logic [PrioWidth-1:0] top_prio,
  output logic [CntWidth-1:0]  depth
);
  import clic_pkg::*;

  // payload storage
  pc_t                  pc_mem   [Depth];
  logic [PrioWidth-1:0] prio_mem [Depth];

  logic                full;
  logic                empty;
  logic [PtrWidth-1:0] wr_ptr;
  logic [PtrWidth-1:0] rd_ptr;

  assign full   = (depth == CntWidth'(Depth));
  assign empty  = (depth == '0);
  // next free slot and current top
  assign wr_ptr = PtrWidth'(depth);
  assign rd_ptr = PtrWidth'(depth - 1'b1);

  // push beyond full is dropped
  always_ff @(posedge clk) begin
    if (push && !full) begin
      pc_mem[wr_ptr]   <= push_pc;
      prio_mem[wr_ptr] <= push_prio;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      depth <= '0;
    end else if (push && !full) begin
      depth <= depth + 1'b1;
    end else if (pop && !empty) begin
      // pop on empty leaves the counter at 0
      depth <= depth - 1'b1;
    end
  end

  // empty stack shows zeros on top
  assign top_pc   = empty ? '0 : pc_mem[rd_ptr];
  assign top_prio = empty ? '0 : prio_mem[rd_ptr];

endmodule

//--- clic/clic_ctrl.sv
// take, tail chain and return decision, threshold update and csr read mux
`timescale 1ns/1ns

module clic_ctrl #(
  parameter  int PrioLevels = 8,
  localparam int PrioWidth  = $clog2(PrioLevels),
  localparam int CntWidth   = $clog2(PrioLevels + 1)
) (
  input  clic_pkg::csr_addr_t  csr_addr,
  input  clic_pkg::pc_t        pc_in,
  // winner from the vector table
  input  logic                 is_int,
  input  logic [PrioWidth-1:0] win_prio,
  input  clic_pkg::vec_t       win_vec,
  input  logic [PrioWidth-1:0] thresh,
  // return stack view
  input  clic_pkg::pc_t        top_pc,
  input  logic [PrioWidth-1:0] top_prio,
  input  logic [CntWidth-1:0]  depth,
  input  clic_pkg::word_t      rdata_tbl,
  output clic_pkg::pc_t        pc_out,
  output logic                 take,
  output logic                 push,
  output logic                 pop,
  output clic_pkg::pc_t        push_pc,
  output logic                 thresh_we,
  output logic [PrioWidth-1:0] thresh_wdata,
  output clic_pkg::word_t      rdata
);
  import clic_pkg::*;

  logic is_ret;

  // core signals mret with the all ones marker
  assign is_ret = (pc_in == ReturnPc);

  // interrupted pc goes on the stack as is
  assign push_pc = pc_in;

  always_comb begin
    // default pass through
    pc_out       = pc_in;
    take         = 1'b0;
    push         = 1'b0;
    pop          = 1'b0;
    thresh_we    = 1'b0;
    thresh_wdata = thresh;
    if (is_int) begin
      // vector is a word address, fetch wants bytes
      pc_out       = {win_vec, 2'b00};
      take         = 1'b1;
      thresh_we    = 1'b1;
      thresh_wdata = win_prio;
      // tail chain on mret, stack untouched
      push         = !is_ret;
    end else if (is_ret) begin
      // plain return, restore pc and level
      // empty stack gives zeros from epc_stack
      pc_out       = top_pc;
      pop          = 1'b1;
      thresh_we    = 1'b1;
      thresh_wdata = top_prio;
    end
  end

  // csr read, fixed csrs first then the table
  always_comb begin
    if (csr_addr == MIntThreshAddr) begin
      rdata = word_t'(thresh);
    end else if (csr_addr == StackDepthAddr) begin
      // read only, no register behind it
      rdata = word_t'(depth);
    end else begin
      rdata = rdata_tbl;
    end
  end

endmodule

//--- clic/n_clic.sv
// clic top level, threshold csr, vector table, control and return stack
`timescale 1ns/1ns

module n_clic #(
  parameter  int VecSize      = 8,
  parameter  int PrioLevels   = 8,
  parameter  int VecCsrBase   = 'hb00,
  parameter  int EntryCsrBase = 'hb20,
  localparam int PrioWidth    = $clog2(PrioLevels),
  localparam int CntWidth     = $clog2(PrioLevels + 1)
) (
  input  logic                 clk,
  input  logic                 arst_n,
  // csr port
  input  logic                 csr_enable,
  input  clic_pkg::csr_addr_t  csr_addr,
  input  clic_pkg::zimm_t      rs1_zimm,
  input  clic_pkg::word_t      rs1_data,
  input  clic_pkg::csr_op_t    csr_op,
  input  logic [VecSize-1:0]   irq,
  // fetch redirect
  input  clic_pkg::pc_t        pc_in,
  output clic_pkg::word_t      rdata,
  output clic_pkg::pc_t        pc_out
);
  import clic_pkg::*;

  logic [PrioWidth-1:0] thresh;
  logic                 thresh_we;
  logic [PrioWidth-1:0] thresh_wdata;
  logic                 is_int;
  logic [PrioWidth-1:0] win_prio;
  vec_t                 win_vec;
  logic                 take;
  word_t                rdata_tbl;
  logic                 push;
  logic                 pop;
  pc_t                  push_pc;
  pc_t                  top_pc;
  logic [PrioWidth-1:0] top_prio;
  logic [CntWidth-1:0]  depth;

  // mintthresh, control rewrites it on take and return
  csr_reg #(
    .Width(PrioWidth),
    .Addr (MIntThreshAddr)
  ) u_thresh (
    .clk             (clk),
    .arst_n          (arst_n),
    .csr_enable      (csr_enable),
    .csr_addr        (csr_addr),
    .rs1_zimm        (rs1_zimm),
    .rs1_data        (rs1_data),
    .csr_op          (csr_op),
    .ext_write_enable(thresh_we),
    .ext_data        (thresh_wdata),
    .data            (thresh)
  );

  // winner index only matters inside the table
  clic_vec_table #(
    .VecSize     (VecSize),
    .PrioLevels  (PrioLevels),
    .VecCsrBase  (VecCsrBase),
    .EntryCsrBase(EntryCsrBase)
  ) u_vec_table (
    .clk       (clk),
    .arst_n    (arst_n),
    .csr_enable(csr_enable),
    .csr_addr  (csr_addr),
    .rs1_zimm  (rs1_zimm),
    .rs1_data  (rs1_data),
    .csr_op    (csr_op),
    .irq       (irq),
    .thresh    (thresh),
    .take      (take),
    .is_int    (is_int),
    .win_prio  (win_prio),
    .win_vec   (win_vec),
    .win_idx   (),
    .rdata_tbl (rdata_tbl)
  );

  clic_ctrl #(
    .PrioLevels(PrioLevels)
  ) u_ctrl (
    .csr_addr    (csr_addr),
    .pc_in       (pc_in),
    .is_int      (is_int),
    .win_prio    (win_prio),
    .win_vec     (win_vec),
    .thresh      (thresh),
    .top_pc      (top_pc),
    .top_prio    (top_prio),
    .depth       (depth),
    .rdata_tbl   (rdata_tbl),
    .pc_out      (pc_out),
    .take        (take),
    .push        (push),
    .pop         (pop),
    .push_pc     (push_pc),
    .thresh_we   (thresh_we),
    .thresh_wdata(thresh_wdata),
    .rdata       (rdata)
  );

  // one slot per priority level, old threshold saved with the pc
  epc_stack #(
    .Depth    (PrioLevels),
    .PrioWidth(PrioWidth)
  ) u_stack (
    .clk      (clk),
    .arst_n   (arst_n),
    .push     (push),
    .pop      (pop),
    .push_pc  (push_pc),
    .push_prio(thresh),
    .top_pc   (top_pc),
    .top_prio (top_prio),
    .depth    (depth)
  );

endmodule

//--- bench/clic_model.svh
// reference model of clic csr state, pend bits, arbitration and return stack
`ifndef CLIC_MODEL_SVH
`define CLIC_MODEL_SVH

// model state, one int per field
int unsigned m_vec  [NumIrq];
int unsigned m_pend [NumIrq];
int unsigned m_en   [NumIrq];
int unsigned m_prio [NumIrq];
int unsigned m_thresh;
int unsigned m_depth;
int unsigned m_stk_pc   [Levels];
int unsigned m_stk_prio [Levels];

// event counters for the end of run summary
int unsigned take_count;
int unsigned tail_count;
int unsigned ret_count;
int unsigned max_depth;

function automatic void reset_model();
  for (int k = 0; k < NumIrq; k++) begin
    m_vec[k]  = 0;
    m_pend[k] = 0;
    m_en[k]   = 0;
    m_prio[k] = 0;
  end
  m_thresh   = 0;
  m_depth    = 0;
  take_count = 0;
  tail_count = 0;
  ret_count  = 0;
  max_depth  = 0;
endfunction

// rw writes, rs sets, rc clears, immediate forms use zimm
function automatic int unsigned csr_result(csr_op_t op, int unsigned cur, word_t data,
                                           zimm_t zimm);
  int unsigned src;
  src = data;
  if (op == csr_rwi || op == csr_rsi || op == csr_rci) begin
    src = 32'(zimm);
  end
  case (op)
    csr_rw, csr_rwi: return src;
    csr_rs, csr_rsi: return cur | src;
    csr_rc, csr_rci: return cur & ~src;
    default: return cur;
  endcase
endfunction

// packed view: prio above enabled above pended
function automatic int unsigned entry_word(int k);
  return (m_prio[k] << 2) | (m_en[k] << 1) | m_pend[k];
endfunction

// -1 when nothing beats the threshold
function automatic int pick_winner();
  int unsigned top;
  bit          found;
  found = 1'b0;
  top   = 0;
  // first pass finds the highest qualifying level
  for (int k = 0; k < NumIrq; k++) begin
    if (m_pend[k] != 0 && m_en[k] != 0 && m_prio[k] > m_thresh) begin
      if (!found || m_prio[k] > top) begin
        top = m_prio[k];
      end
      found = 1'b1;
    end
  end
  if (!found) begin
    return -1;
  end
  // second pass, lowest index at that level
  for (int k = 0; k < NumIrq; k++) begin
    if (m_pend[k] != 0 && m_en[k] != 0 && m_prio[k] == top) begin
      return k;
    end
  end
  return -1;
endfunction

function automatic int unsigned expected_rdata(csr_addr_t addr);
  if (addr == MIntThreshAddr) begin
    return m_thresh;
  end
  if (addr == StackDepthAddr) begin
    return m_depth;
  end
  for (int k = 0; k < NumIrq; k++) begin
    if (addr == csr_addr_t'(VecBase + k)) begin
      return m_vec[k];
    end
    if (addr == csr_addr_t'(EntryBase + k)) begin
      return entry_word(k);
    end
  end
  return 0;
endfunction

function automatic int unsigned expected_pc(pc_t pc);
  int w;
  w = pick_winner();
  // take and tail chain both jump to the vector
  if (w >= 0) begin
    return m_vec[w] << 2;
  end
  if (pc == ReturnPc) begin
    return (m_depth > 0) ? m_stk_pc[m_depth - 1] : 0;
  end
  return 32'(pc);
endfunction

// one clock edge with the inputs that were on the port during the cycle
task automatic update_model(input logic en, input csr_addr_t addr, input zimm_t zimm,
                            input word_t data, input csr_op_t op,
                            input logic [NumIrq-1:0] irq_v, input pc_t pc);
  int          w;
  bit          is_ret;
  bit          hit;
  bit          hw_we;
  int unsigned hw_val;
  int unsigned old_thresh;
  int unsigned e;
  w          = pick_winner();
  is_ret     = (pc == ReturnPc);
  hit        = en && (op != csr_none);
  old_thresh = m_thresh;
  hw_we      = 1'b0;
  hw_val     = 0;
  if (w >= 0) begin
    hw_we  = 1'b1;
    hw_val = m_prio[w];
    take_count++;
    if (is_ret) begin
      tail_count++;
    end else if (m_depth < Levels) begin
      // interrupted pc and the level it ran at
      m_stk_pc[m_depth]   = 32'(pc);
      m_stk_prio[m_depth] = old_thresh;
      m_depth++;
      if (m_depth > max_depth) begin
        max_depth = m_depth;
      end
    end
  end else if (is_ret) begin
    hw_we = 1'b1;
    ret_count++;
    // empty stack restores level 0
    if (m_depth > 0) begin
      m_depth--;
      hw_val = m_stk_prio[m_depth];
    end
  end
  // control update wins over software
  if (hw_we) begin
    m_thresh = hw_val;
  end else if (hit && addr == MIntThreshAddr) begin
    m_thresh = csr_result(op, old_thresh, data, zimm) & PrioMask;
  end
  for (int k = 0; k < NumIrq; k++) begin
    if (hit && addr == csr_addr_t'(VecBase + k)) begin
      m_vec[k] = csr_result(op, m_vec[k], data, zimm) & VecMask;
    end
    e = entry_word(k);
    if (hit && addr == csr_addr_t'(EntryBase + k)) begin
      e = csr_result(op, e, data, zimm) & EntryMask;
    end
    // line sets over a csr clear, take clears over both
    if (irq_v[k]) begin
      e = e | 1;
    end
    if (w == k) begin
      e = e & ~32'h1;
    end
    m_pend[k] = e & 1;
    m_en[k]   = (e >> 1) & 1;
    m_prio[k] = e >> 2;
  end
endtask

`endif

//--- bench/clic_tb.sv
// clic testbench: clock, reset, directed and random stimulus, model checks and watchdog
`timescale 1ns/1ns

module clic_tb;
  import clic_pkg::*;

  localparam int          NumIrq      = 8;
  localparam int          Levels      = 8;
  localparam int          VecBase     = 'hb00;
  localparam int          EntryBase   = 'hb20;
  localparam int unsigned PrioMask    = 32'h7;
  localparam int unsigned EntryMask   = 32'h1f;
  localparam int unsigned VecMask     = 32'h3fff;
  localparam int          ResetCycles = 5;
  localparam int          DirectedOps = 64;
  localparam int          RandomOps   = 1500;
  localparam int          TotalOps    = ResetCycles + DirectedOps + 2 * RandomOps;

  logic              clk;
  logic              arst_n;
  logic              csr_enable;
  csr_addr_t         csr_addr;
  zimm_t             rs1_zimm;
  word_t             rs1_data;
  csr_op_t           csr_op;
  logic [NumIrq-1:0] irq;
  pc_t               pc_in;
  word_t             rdata;
  pc_t               pc_out;
  int                seed;

  `include "clic_model.svh"

  // default parameters, 8 lines and 8 levels
  n_clic dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .csr_enable(csr_enable),
    .csr_addr  (csr_addr),
    .rs1_zimm  (rs1_zimm),
    .rs1_data  (rs1_data),
    .csr_op    (csr_op),
    .irq       (irq),
    .pc_in     (pc_in),
    .rdata     (rdata),
    .pc_out    (pc_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // 4x margin over one op per clock
  initial begin
    #(TotalOps * 20 * 4);
    $display("watchdog expired before the test sequence finished");
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // model sees the edge first, then new inputs, outputs checked mid cycle
  task automatic apply_op(input logic en, input csr_addr_t addr, input zimm_t zimm,
                          input word_t data, input csr_op_t op,
                          input logic [NumIrq-1:0] irq_v, input pc_t pc);
    @(posedge clk);
    update_model(csr_enable, csr_addr, rs1_zimm, rs1_data, csr_op, irq, pc_in);
    csr_enable <= en;
    csr_addr   <= addr;
    rs1_zimm   <= zimm;
    rs1_data   <= data;
    csr_op     <= op;
    irq        <= irq_v;
    pc_in      <= pc;
    @(negedge clk);
    check_value("rdata", rdata, expected_rdata(addr));
    check_value("pc_out", 32'(pc_out), expected_pc(pc));
  endtask

  task automatic random_op(input int unsigned ret_pct);
    int unsigned       r;
    int unsigned       k;
    csr_addr_t         addr;
    logic              en;
    csr_op_t           op;
    pc_t               pc;
    logic [NumIrq-1:0] irq_v;
    r = $unsigned($random(seed)) % 16;
    k = $unsigned($random(seed)) % NumIrq;
    // entries most often, they drive arbitration
    if (r < 3) begin
      addr = MIntThreshAddr;
    end else if (r < 4) begin
      addr = StackDepthAddr;
    end else if (r < 10) begin
      addr = csr_addr_t'(EntryBase + k);
    end else if (r < 13) begin
      addr = csr_addr_t'(VecBase + k);
    end else begin
      addr = csr_addr_t'($random(seed));
    end
    en    = ($random(seed) & 3) != 0;
    op    = csr_op_t'(3'($unsigned($random(seed)) % 7));
    irq_v = NumIrq'($random(seed) & $random(seed) & $random(seed));
    // word aligned pc never equals the return marker
    pc    = pc_t'($random(seed)) & 16'hfffc;
    if ($unsigned($random(seed)) % 100 < ret_pct) begin
      pc = ReturnPc;
    end
    apply_op(en, addr, zimm_t'($random(seed)), word_t'($random(seed)), op, irq_v, pc);
  endtask

  task automatic directed_sequence();
    pc_t pc;
    // return with nothing saved
    apply_op(1'b0, MIntThreshAddr, '0, '0, csr_none, '0, ReturnPc);
    apply_op(1'b0, MIntThreshAddr, '0, '0, csr_none, '0, 16'h0100);
    for (int k = 0; k < NumIrq; k++) begin
      apply_op(1'b1, csr_addr_t'(VecBase + k), '0, word_t'(32'h100 + k * 64), csr_rw,
               '0, 16'h0100);
    end
    // line 0 at level 7, line 1 at level 5, both enabled
    apply_op(1'b1, csr_addr_t'(EntryBase), '0, 32'd30, csr_rw, '0, 16'h0104);
    apply_op(1'b1, csr_addr_t'(EntryBase + 1), '0, 32'd22, csr_rw, '0, 16'h0108);
    // irq line against a csr clear of the same pend bit
    apply_op(1'b1, csr_addr_t'(EntryBase + 2), '0, 32'h1, csr_rc, 8'h04, 16'h010c);
    apply_op(1'b0, csr_addr_t'(EntryBase + 2), '0, '0, csr_none, '0, 16'h0110);
    // take, then drop the level again, until the stack saturates
    for (int i = 0; i < 10; i++) begin
      pc = pc_t'(16'h1000 + i * 4);
      apply_op(1'b0, StackDepthAddr, '0, '0, csr_none, 8'h01, pc);
      apply_op(1'b0, StackDepthAddr, '0, '0, csr_none, '0, pc);
      apply_op(1'b1, MIntThreshAddr, '0, '0, csr_rw, '0, pc);
    end
    // take line 1, pend line 0, then mret chains into line 0
    apply_op(1'b0, MIntThreshAddr, '0, '0, csr_none, 8'h02, 16'h2000);
    apply_op(1'b0, StackDepthAddr, '0, '0, csr_none, '0, 16'h2004);
    apply_op(1'b0, MIntThreshAddr, '0, '0, csr_none, 8'h01, 16'h2008);
    apply_op(1'b0, StackDepthAddr, '0, '0, csr_none, '0, ReturnPc);
    // unwind past the bottom
    for (int i = 0; i < 10; i++) begin
      apply_op(1'b0, (i % 2 == 0) ? MIntThreshAddr : StackDepthAddr, '0, '0, csr_none,
               '0, ReturnPc);
    end
    apply_op(1'b1, StackDepthAddr, '0, 32'h5, csr_rw, '0, 16'h3000);
    apply_op(1'b0, 12'h7ff, '0, '0, csr_none, '0, 16'h3004);
  endtask

  initial begin
    seed = 62169;
    arst_n     <= 1'b0;
    csr_enable <= 1'b0;
    csr_addr   <= '0;
    rs1_zimm   <= '0;
    rs1_data   <= '0;
    csr_op     <= csr_none;
    irq        <= '0;
    pc_in      <= '0;
    reset_model();
    repeat (ResetCycles) @(posedge clk);
    arst_n <= 1'b1;
    directed_sequence();
    // few returns lets the stack build up, many returns drains it
    repeat (RandomOps) random_op(8);
    repeat (RandomOps) random_op(30);
    if (take_count == 0 || tail_count == 0 || ret_count == 0 || max_depth != Levels) begin
      $display("expected take, tail chain, return and full stack events did not all occur");
      $display("Simulation failed");
      $fatal(1, "missing events");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

//--- list.f
+incdir+bench
common/clic_pkg.sv
clic/csr_reg.sv
clic/clic_vec_table.sv
clic/epc_stack.sv
clic/clic_ctrl.sv
clic/n_clic.sv
bench/clic_tb.sv

//--- run.sh
#!/bin/sh
# build the clic testbench with verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f list.f --top-module clic_tb --Mdir obj_dir -o clic_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/clic_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL: pass line not found in $LOG"
  exit 1
fi
